//--- src/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// byte address width
`define ADDRESS_LEN 32

// data word and memory cell widths
`define WORD_LEN 32
`define BYTE_LEN 8

// number of bytes held by the data memory
`define MEM_SIZE 64

// first byte address of the memory window
`define MEM_BASE 1024

`endif

//--- src/lsuPkg.sv
package lsuPkg;

	// memory opcodes carried with every request
	// memNop passes through the pipeline and returns zero data
	// memLoadWord reads an aligned big-endian word
	// memLoadByte and memLoadByteU read one byte and extend it
	// memStoreWord writes an aligned big-endian word
	typedef enum logic [2:0] {
		memNop       = 3'd0,
		memLoadWord  = 3'd1,
		memLoadByte  = 3'd2,
		memLoadByteU = 3'd3,
		memStoreWord = 3'd4
	} memOp;

	// values 5 to 7 are unused encodings
	// a request carrying one of them is a stimulus error

	// upper bound used by range checks in the stages
	localparam int memOpCount = 5;

endpackage

//--- src/stageBus.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

// one request as it moves between two pipeline stages
interface stageBus;

	// one-cycle strobe per request, no back-pressure
	logic valid;
	lsuPkg::memOp op;

	// byte address relative to the memory window
	logic [`ADDRESS_LEN-1:0] address;

	// store data on the way in, read word on the way out
	logic [`WORD_LEN-1:0] data;

	// out of window or misaligned word access
	logic fault;

	// the stage that registers the request
	modport source (output valid, output op, output address, output data, output fault);

	// the stage that consumes it
	modport sink (input valid, input op, input address, input data, input fault);

endinterface

//--- src/addressStage.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module addressStage (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input lsuPkg::memOp reqOp,
	input logic [`ADDRESS_LEN-1:0] reqBase,
	input logic signed [15:0] reqOffset,
	input logic [`WORD_LEN-1:0] reqStoreData,
	stageBus.source outBus
);

	logic [`ADDRESS_LEN-1:0] effAddress;
	logic [`ADDRESS_LEN-1:0] relAddress;
	logic isWordOp;
	logic outOfRange;
	logic misaligned;
	logic faultNext;

	// offset is sign-extended to the full address width before the add
	assign effAddress = reqBase + {{(`ADDRESS_LEN - 16){reqOffset[15]}}, reqOffset};

	// addresses below the window wrap to large values and fail the range check
	assign relAddress = effAddress - `ADDRESS_LEN'(`MEM_BASE);
	assign outOfRange = relAddress >= `ADDRESS_LEN'(`MEM_SIZE);

	assign isWordOp = (reqOp == lsuPkg::memLoadWord) || (reqOp == lsuPkg::memStoreWord);

	// window base is word aligned, so the relative low bits give alignment
	assign misaligned = isWordOp && (relAddress[1:0] != 2'b00);

	// a nop never faults whatever its address fields hold
	assign faultNext = reqValid && (reqOp != lsuPkg::memNop) && (outOfRange || misaligned);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			outBus.valid <= 1'b0;
			outBus.op <= lsuPkg::memNop;
			outBus.fault <= 1'b0;
		end else begin
			outBus.valid <= reqValid;
			outBus.op <= reqOp;
			outBus.fault <= faultNext;
		end
	end

	// relative address and store data of the request
	always_ff @(posedge clk) begin
		outBus.address <= relAddress;
		outBus.data <= reqStoreData;
	end

	// every accepted request must carry one of the defined opcodes
	opKnown: assert property (
		@(posedge clk) disable iff (rst)
		reqValid |-> (int'(reqOp) < lsuPkg::memOpCount)
	) else $error("addressStage: undefined opcode %0d on a valid request", reqOp);

endmodule

//--- src/dataMemory.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module dataMemory (
	input logic clk,
	input logic rst,
	stageBus.sink inBus,
	stageBus.source outBus
);

	localparam int indexLen = $clog2(`MEM_SIZE);
	localparam int imageBytes = 16;

	// first four words after reset, byte 0 leftmost
	localparam logic [imageBytes*`BYTE_LEN-1:0] resetImage =
		128'h10000000_C0220000_00640000_00A60000;

	logic [`BYTE_LEN-1:0] mem [0:`MEM_SIZE-1];
	logic [indexLen-1:0] baseIndex;
	logic writeEnable;
	logic isLoad;
	logic [`WORD_LEN-1:0] readWord;

	// big-endian word at an aligned byte index
	function automatic logic [`WORD_LEN-1:0] wordAt(input logic [indexLen-1:0] index);
		return {
			mem[{index[indexLen-1:2], 2'b00}],
			mem[{index[indexLen-1:2], 2'b01}],
			mem[{index[indexLen-1:2], 2'b10}],
			mem[{index[indexLen-1:2], 2'b11}]
		};
	endfunction

	// faulting requests may carry any address, only in-range ones reach memory
	assign baseIndex = {inBus.address[indexLen-1:2], 2'b00};

	assign writeEnable = inBus.valid && !inBus.fault && (inBus.op == lsuPkg::memStoreWord);

	assign isLoad = inBus.valid && !inBus.fault &&
		(inBus.op inside {lsuPkg::memLoadWord, lsuPkg::memLoadByte, lsuPkg::memLoadByteU});

	always_comb begin
		readWord = wordAt(baseIndex);
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < imageBytes; i++) begin
				mem[i] <= resetImage[(imageBytes - i) * `BYTE_LEN - 1 -: `BYTE_LEN];
			end
			for (int i = imageBytes; i < `MEM_SIZE; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEnable) begin
			// most significant byte lands on the aligned address
			mem[{baseIndex[indexLen-1:2], 2'b00}] <= inBus.data[4*`BYTE_LEN-1 -: `BYTE_LEN];
			mem[{baseIndex[indexLen-1:2], 2'b01}] <= inBus.data[3*`BYTE_LEN-1 -: `BYTE_LEN];
			mem[{baseIndex[indexLen-1:2], 2'b10}] <= inBus.data[2*`BYTE_LEN-1 -: `BYTE_LEN];
			mem[{baseIndex[indexLen-1:2], 2'b11}] <= inBus.data[`BYTE_LEN-1 -: `BYTE_LEN];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			outBus.valid <= 1'b0;
			outBus.op <= lsuPkg::memNop;
			outBus.fault <= 1'b0;
		end else begin
			outBus.valid <= inBus.valid;
			outBus.op <= inBus.op;
			outBus.fault <= inBus.fault;
		end
	end

	// read happens before the write of the same edge lands,
	// so a store reports zero and a following load sees the new word
	always_ff @(posedge clk) begin
		outBus.address <= inBus.address;
		outBus.data <= isLoad ? readWord : '0;
	end

	// a faulting request must leave the word it points at untouched
	faultNoWrite: assert property (
		@(posedge clk) disable iff (rst)
		(inBus.valid && inBus.fault) |=> (wordAt($past(baseIndex)) == $past(readWord))
	) else $error("dataMemory: memory changed under a faulting request");

endmodule

//--- src/writebackStage.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module writebackStage (
	input logic clk,
	input logic rst,
	stageBus.sink inBus,
	output logic resultValid,
	output lsuPkg::memOp resultOp,
	output logic [`WORD_LEN-1:0] resultData,
	output logic resultFault
);

	logic [`BYTE_LEN-1:0] selByte;
	logic [`WORD_LEN-1:0] resultNext;

	// byte 0 is the most significant byte of the word
	always_comb begin
		case (inBus.address[1:0])
			2'd0: selByte = inBus.data[4*`BYTE_LEN-1 -: `BYTE_LEN];
			2'd1: selByte = inBus.data[3*`BYTE_LEN-1 -: `BYTE_LEN];
			2'd2: selByte = inBus.data[2*`BYTE_LEN-1 -: `BYTE_LEN];
			default: selByte = inBus.data[`BYTE_LEN-1 -: `BYTE_LEN];
		endcase
	end

	always_comb begin
		resultNext = '0;
		if (inBus.valid && !inBus.fault) begin
			case (inBus.op)
				lsuPkg::memLoadWord: resultNext = inBus.data;
				lsuPkg::memLoadByte:
					resultNext = {{(`WORD_LEN - `BYTE_LEN){selByte[`BYTE_LEN-1]}}, selByte};
				lsuPkg::memLoadByteU:
					resultNext = {{(`WORD_LEN - `BYTE_LEN){1'b0}}, selByte};
				// stores and nops report zero
				default: resultNext = '0;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			resultValid <= 1'b0;
			resultOp <= lsuPkg::memNop;
			resultFault <= 1'b0;
		end else begin
			resultValid <= inBus.valid;
			resultOp <= inBus.op;
			// fault is already qualified by valid in the address stage
			resultFault <= inBus.fault;
		end
	end

	always_ff @(posedge clk) begin
		resultData <= resultNext;
	end

	// fault travels two stages with its strobe and never shows up alone
	faultHasValid: assert property (
		@(posedge clk) disable iff (rst)
		resultFault |-> resultValid
	) else $error("writebackStage: resultFault without resultValid");

endmodule

//--- src/loadStoreUnit.sv
`timescale 1ns/10ps
`include "lsu_consts.svh"

module loadStoreUnit (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input lsuPkg::memOp reqOp,
	input logic [`ADDRESS_LEN-1:0] reqBase,
	input logic signed [15:0] reqOffset,
	input logic [`WORD_LEN-1:0] reqStoreData,
	output logic resultValid,
	output lsuPkg::memOp resultOp,
	output logic [`WORD_LEN-1:0] resultData,
	output logic resultFault
);

	// address stage to memory, data carries the store word
	stageBus addrToMem ();

	// memory to writeback, data carries the aligned read word
	stageBus memToWb ();

	addressStage uAddressStage (
		.clk          (clk),
		.rst          (rst),
		.reqValid     (reqValid),
		.reqOp        (reqOp),
		.reqBase      (reqBase),
		.reqOffset    (reqOffset),
		.reqStoreData (reqStoreData),
		.outBus       (addrToMem.source)
	);

	// store and read share this stage, so no forwarding is needed
	dataMemory uDataMemory (
		.clk    (clk),
		.rst    (rst),
		.inBus  (addrToMem.sink),
		.outBus (memToWb.source)
	);

	writebackStage uWritebackStage (
		.clk         (clk),
		.rst         (rst),
		.inBus       (memToWb.sink),
		.resultValid (resultValid),
		.resultOp    (resultOp),
		.resultData  (resultData),
		.resultFault (resultFault)
	);

endmodule

//--- verification/lsuTb.sv
`timescale 1ns/10ps

module lsuTb;

	localparam int randomSeed = 97377;
	localparam int memBase = 1024;
	localparam int memSize = 64;
	localparam int directedRequests = 31;
	localparam int randomRequests = 200;
	localparam int timeoutCycles = 2 * (directedRequests + randomRequests) + 50;
	localparam int latency = 3;
	localparam int drainCycles = latency + 2;

	logic clk;
	logic rst;
	logic reqValid;
	lsuPkg::memOp reqOp;
	logic [31:0] reqBase;
	logic signed [15:0] reqOffset;
	logic [31:0] reqStoreData;
	logic resultValid;
	lsuPkg::memOp resultOp;
	logic [31:0] resultData;
	logic resultFault;

	// each entry is {fault, op, data} and dueQ holds the cycle it is due in
	logic [35:0] expectQ [$];
	int dueQ [$];
	logic [7:0] model [0:memSize-1];

	int cycleCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int testStartErrors = 0;
	int seedValue;
	int opSel;
	int offsetVal;
	logic [31:0] baseVal;
	logic [35:0] expected;
	int dueCycle;

	loadStoreUnit DUT (
		.clk          (clk),
		.rst          (rst),
		.reqValid     (reqValid),
		.reqOp        (reqOp),
		.reqBase      (reqBase),
		.reqOffset    (reqOffset),
		.reqStoreData (reqStoreData),
		.resultValid  (resultValid),
		.resultOp     (resultOp),
		.resultData   (resultData),
		.resultFault  (resultFault)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// memory contents right after reset with word 0 at the lowest addresses
	task automatic resetModel();
		for (int i = 0; i < memSize; i++) begin
			model[i] = 8'h00;
		end
		model[0] = 8'h10;
		model[4] = 8'hC0;
		model[5] = 8'h22;
		model[9] = 8'h64;
		model[13] = 8'hA6;
	endtask

	// expected {fault, op, data} for one request and the model update of a store
	function automatic logic [35:0] refModel(input lsuPkg::memOp op, input logic [31:0] base,
			input logic signed [15:0] offset, input logic [31:0] storeData);
		logic [31:0] effAddr;
		logic [31:0] relAddr;
		logic [5:0] wordIdx;
		logic [7:0] pickedByte;
		logic isWord;
		logic fault;
		logic [31:0] data;
		effAddr = base + {{16{offset[15]}}, offset};
		relAddr = effAddr - 32'(memBase);
		isWord = (op == lsuPkg::memLoadWord) || (op == lsuPkg::memStoreWord);
		fault = (op != lsuPkg::memNop) &&
			((relAddr >= 32'(memSize)) || (isWord && (relAddr[1:0] != 2'b00)));
		data = '0;
		wordIdx = {relAddr[5:2], 2'b00};
		pickedByte = model[relAddr[5:0]];
		if (!fault) begin
			case (op)
				lsuPkg::memLoadWord: data = {model[wordIdx], model[wordIdx + 6'd1],
					model[wordIdx + 6'd2], model[wordIdx + 6'd3]};
				lsuPkg::memLoadByte: data = {{24{pickedByte[7]}}, pickedByte};
				lsuPkg::memLoadByteU: data = {24'h000000, pickedByte};
				lsuPkg::memStoreWord: begin
					model[wordIdx] = storeData[31:24];
					model[wordIdx + 6'd1] = storeData[23:16];
					model[wordIdx + 6'd2] = storeData[15:8];
					model[wordIdx + 6'd3] = storeData[7:0];
				end
				default: data = '0;
			endcase
		end
		return {fault, op, data};
	endfunction

	task automatic sendRequest(input lsuPkg::memOp op, input logic [31:0] base,
			input int offset, input logic [31:0] storeData);
		logic signed [15:0] offs;
		offs = 16'(offset);
		@(posedge clk);
		#1;
		expectQ.push_back(refModel(op, base, offs, storeData));
		dueQ.push_back(cycleCount + latency);
		reqValid = 1'b1;
		reqOp = op;
		reqBase = base;
		reqOffset = offs;
		reqStoreData = storeData;
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#1;
		reqValid = 1'b0;
		reqOp = lsuPkg::memNop;
		reqBase = '0;
		reqOffset = '0;
		reqStoreData = '0;
	endtask

	task automatic finishTest(input string name);
		int waited;
		idleCycle();
		waited = 0;
		while (expectQ.size() != 0 && waited < drainCycles) begin
			@(negedge clk);
			waited++;
		end
		if (expectQ.size() != 0) begin
			$display("test %s: %0d results did not come out", name, expectQ.size());
			errorCount++;
		end
		if (errorCount == testStartErrors) begin
			testsPassed++;
			$display("test %s: passed", name);
		end else begin
			testsFailed++;
			$display("test %s: failed with %0d errors", name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	// cycle counter and run limit
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("run stopped after %0d cycles with %0d results still outstanding",
				cycleCount, expectQ.size());
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && resultValid) begin
			if (expectQ.size() == 0) begin
				$display("a result came out with no request outstanding");
				errorCount++;
			end else begin
				expected = expectQ.pop_front();
				dueCycle = dueQ.pop_front();
				checkCount++;
				if (cycleCount != dueCycle) begin
					$display("result came out in cycle %0d instead of cycle %0d",
						cycleCount, dueCycle);
					errorCount++;
				end
				if (resultFault !== expected[35]) begin
					$display("[ERROR] resultFault expected %h got %h", expected[35], resultFault);
					errorCount++;
				end
				if (resultOp !== lsuPkg::memOp'(expected[34:32])) begin
					$display("[ERROR] resultOp expected %h got %h", expected[34:32], resultOp);
					errorCount++;
				end
				if (resultData !== expected[31:0]) begin
					$display("[ERROR] resultData expected %h got %h", expected[31:0], resultData);
					errorCount++;
				end
			end
		end
	end

	initial begin
		seedValue = $urandom(randomSeed);
		rst = 1'b1;
		reqValid = 1'b0;
		reqOp = lsuPkg::memNop;
		reqBase = '0;
		reqOffset = '0;
		reqStoreData = '0;
		resetModel();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		for (int i = 0; i < 4; i++) begin
			sendRequest(lsuPkg::memLoadWord, 32'd1024, 4 * i, 32'h0);
		end
		finishTest("reset image");

		// each load follows its store on the next cycle
		for (int i = 0; i < 4; i++) begin
			sendRequest(lsuPkg::memStoreWord, 32'd1024, 16 + 4 * i, 32'hA5000000 + 32'(i * 257));
			sendRequest(lsuPkg::memLoadWord, 32'd1024, 16 + 4 * i, 32'h0);
		end
		finishTest("store then load");

		// bytes alternate between top bit set and clear
		sendRequest(lsuPkg::memStoreWord, 32'd1024, 32, 32'h807FFF01);
		for (int i = 0; i < 4; i++) begin
			sendRequest(lsuPkg::memLoadByte, 32'd1024, 32 + i, 32'h0);
			sendRequest(lsuPkg::memLoadByteU, 32'd1024, 32 + i, 32'h0);
		end
		finishTest("byte loads");

		sendRequest(lsuPkg::memLoadWord, 32'd1024, -4, 32'h0);
		sendRequest(lsuPkg::memLoadByteU, 32'd1000, 0, 32'h0);
		sendRequest(lsuPkg::memLoadWord, 32'd1024, memSize, 32'h0);
		sendRequest(lsuPkg::memLoadByte, 32'd1024, 200, 32'h0);
		sendRequest(lsuPkg::memLoadWord, 32'd1024, 2, 32'h0);
		sendRequest(lsuPkg::memStoreWord, 32'd1024, 5, 32'hDEADBEEF);
		sendRequest(lsuPkg::memStoreWord, 32'd1024, memSize, 32'h12345678);
		// words 4 and 0 must still hold their reset values
		sendRequest(lsuPkg::memLoadWord, 32'd1024, 4, 32'h0);
		sendRequest(lsuPkg::memLoadWord, 32'd1024, 0, 32'h0);
		sendRequest(lsuPkg::memNop, 32'd1024, 1, 32'h0);
		finishTest("faults");

		for (int i = 0; i < randomRequests; i++) begin
			if ($urandom % 8 == 0) begin
				idleCycle();
			end
			opSel = int'($urandom % 5);
			if ($urandom % 2 == 0) begin
				baseVal = 32'd1024;
				offsetVal = int'($urandom % 80) - 8;
			end else begin
				baseVal = 32'd1000;
				offsetVal = int'($urandom % 80) + 16;
			end
			sendRequest(lsuPkg::memOp'(3'(opSel)), baseVal, offsetVal, $urandom);
		end
		finishTest("random stream");

		if (expectQ.size() != 0) begin
			$display("%0d expected results never came out", expectQ.size());
			errorCount++;
		end
		$display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
			testsPassed, testsFailed, checkCount, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+src
src/lsuPkg.sv
src/stageBus.sv
src/addressStage.sv
src/dataMemory.sv
src/writebackStage.sv
src/loadStoreUnit.sv
verification/lsuTb.sv

//--- run.sh
#!/bin/sh
# compile and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module lsuTb -o lsuSim > build.log 2>&1 \
	&& ./obj_dir/lsuSim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
